//--- rtl/pmem_bank_ctrl.sv
`timescale 1ns/100ps

module pmem_bank_ctrl (
    input  logic                 bus_clk,
    input  logic                 rst_n,

    input  pmem_pkg::pmem_req_t  held,
    input  logic                 ser_empty,

    output logic                 consume,
    output pmem_pkg::pmem_resp_t rd_resp
);

    logic [pmem_pkg::DATA_W-1:0]     mem [pmem_pkg::BANK_WORDS];
    logic [pmem_pkg::BANK_WORDS-1:0] written;
    logic [pmem_pkg::DATA_W-1:0]     rd_word;

    logic                        busy;
    logic [pmem_pkg::CNT_W-1:0]  cnt;
    logic [pmem_pkg::BANK_AW-1:0] idx;

    logic start;
    logic done;
    logic wr_done;

    // Word index from the upper address bits
    assign idx = held.addr[pmem_pkg::ADDR_W-1 -: pmem_pkg::BANK_AW];

    assign start = held.valid && !busy;

    // Count ends at one; reads also wait for room in the serializer
    assign done    = busy && (cnt == pmem_pkg::CNT_W'(1)) && (!held.rw || ser_empty);
    assign wr_done = done && !held.rw;

    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            if (held.rw) begin
                cnt <= pmem_pkg::CNT_W'(pmem_pkg::READ_CYCLES);
            end else begin
                cnt <= pmem_pkg::CNT_W'(pmem_pkg::WRITE_CYCLES);
            end
        end else if (done) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (busy && cnt > pmem_pkg::CNT_W'(1)) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Words never written read back as zero
    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            written <= '0;
        end else if (wr_done) begin
            written[idx] <= 1'b1;
        end
    end

    // Storage array
    always_ff @(posedge bus_clk) begin
        if (wr_done) begin
            mem[idx] <= held.data;
        end
    end

    // Read word settles while the timer runs
    always_ff @(posedge bus_clk) begin
        if (busy) begin
            rd_word <= written[idx] ? mem[idx] : '0;
        end
    end

    assign consume = done;

    // Bank id is stamped later by the bus stage
    always_comb begin
        rd_resp       = '0;
        rd_resp.valid = done && held.rw;
        rd_resp.dest  = held.src;
        rd_resp.addr  = held.addr;
        rd_resp.data  = rd_word;
    end

endmodule

//--- rtl/pmem_pkg.sv
package pmem_pkg;

    // Bank organisation
    localparam int PMEM_BANKS = 4;
    localparam int ADDR_W     = 15;
    localparam int BANK_AW    = 9;
    localparam int DATA_W     = 128;

    // Bus agent ids, bank i answers as BANK_ID_BASE + i
    localparam int ID_W = 4;
    localparam logic [ID_W-1:0] BANK_ID_BASE = 4'h8;

    // Access times in bus clock cycles
    localparam int READ_CYCLES  = 3;
    localparam int WRITE_CYCLES = 2;

    // Wide enough for the longer of the two access times
    localparam int CNT_W = $clog2(
        (READ_CYCLES > WRITE_CYCLES ? READ_CYCLES : WRITE_CYCLES) + 1);

    localparam int BANK_WORDS = 2 ** BANK_AW;

    // Request packet, driven by the bus master
    typedef struct packed {
        logic              valid;
        logic              rw;     // 1 = read
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [ID_W-1:0]   src;    // requester to answer
    } pmem_req_t;

    // Response packet, read results only
    typedef struct packed {
        logic              valid;
        logic [ID_W-1:0]   dest;
        logic [ID_W-1:0]   src;    // answering bank
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } pmem_resp_t;

endpackage

//--- rtl/pmem_req_deser.sv
`timescale 1ns/100ps

module pmem_req_deser (
    input  logic                bus_clk,
    input  logic                rst_n,

    input  logic                recv,
    input  pmem_pkg::pmem_req_t req_in,
    input  logic                consume,

    output pmem_pkg::pmem_req_t held,
    output logic                free
);

    pmem_pkg::pmem_req_t pkt_q;
    logic                full;
    logic                load;

    // A strobe while full is dropped here
    assign load = recv && !full;

    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (consume) begin
            full <= 1'b0;
        end
    end

    // Packet payload
    always_ff @(posedge bus_clk) begin
        if (load) begin
            pkt_q <= req_in;
        end
    end

    always_comb begin
        held       = pkt_q;
        held.valid = full;
    end

    assign free = !full;

endmodule

//--- rtl/pmem_resp_bus.sv
`timescale 1ns/100ps

module pmem_resp_bus (
    input  logic                 bus_clk,
    input  logic                 rst_n,

    input  pmem_pkg::pmem_resp_t offers [pmem_pkg::PMEM_BANKS],

    output pmem_pkg::pmem_resp_t resp_out
);

    pmem_pkg::pmem_resp_t sel;
    pmem_pkg::pmem_resp_t resp_q;
    logic                 valid_q;

    // At most one bank is granted, so at most one offer is valid
    always_comb begin
        sel = '0;
        for (int i = 0; i < pmem_pkg::PMEM_BANKS; i++) begin
            if (offers[i].valid) begin
                sel     = offers[i];
                sel.src = pmem_pkg::BANK_ID_BASE + pmem_pkg::ID_W'(i);
            end
        end
    end

    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= sel.valid;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (sel.valid) begin
            resp_q <= sel;
        end
    end

    always_comb begin
        resp_out       = resp_q;
        resp_out.valid = valid_q;
    end

endmodule

//--- rtl/pmem_resp_ser.sv
`timescale 1ns/100ps

module pmem_resp_ser (
    input  logic                 bus_clk,
    input  logic                 rst_n,

    input  pmem_pkg::pmem_resp_t rd_resp,
    input  logic                 grant,
    input  logic                 ack,

    output logic                 req,
    output logic                 rel,
    output logic                 ser_empty,
    output pmem_pkg::pmem_resp_t offer
);

    typedef enum logic [1:0] {
        S_EMPTY,
        S_REQ,
        S_SENT,
        S_REL
    } state_t;

    state_t state;
    state_t state_nxt;

    pmem_pkg::pmem_resp_t resp_q;
    logic                 load;
    logic                 send;

    assign load = (state == S_EMPTY) && rd_resp.valid;
    assign send = (state == S_REQ) && grant;

    always_comb begin
        state_nxt = state;
        case (state)
            S_EMPTY: begin
                if (rd_resp.valid) begin
                    state_nxt = S_REQ;
                end
            end
            S_REQ: begin
                if (grant) begin
                    state_nxt = S_SENT;
                end
            end
            // Hold the bus until the receiver acknowledges
            S_SENT: begin
                if (ack) begin
                    state_nxt = S_REL;
                end
            end
            S_REL: begin
                state_nxt = S_EMPTY;
            end
            default: begin
                state_nxt = S_EMPTY;
            end
        endcase
    end

    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_EMPTY;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (load) begin
            resp_q <= rd_resp;
        end
    end

    assign req       = (state == S_REQ) || (state == S_SENT);
    assign rel       = (state == S_REL);
    assign ser_empty = (state == S_EMPTY);

    // One offer cycle, on the first granted cycle
    always_comb begin
        offer       = resp_q;
        offer.valid = send;
    end

endmodule

//--- rtl/pmem_top.sv
`timescale 1ns/100ps

module pmem_top (
    input  logic                               bus_clk,
    input  logic                               rst_n,

    input  pmem_pkg::pmem_req_t                req_in,
    input  logic [pmem_pkg::PMEM_BANKS-1:0]    recv,
    input  logic [pmem_pkg::PMEM_BANKS-1:0]    grant,
    input  logic [pmem_pkg::PMEM_BANKS-1:0]    ack,

    output logic [pmem_pkg::PMEM_BANKS-1:0]    free,
    output logic [pmem_pkg::PMEM_BANKS-1:0]    req,
    output logic [pmem_pkg::PMEM_BANKS-1:0]    rel,
    output pmem_pkg::pmem_resp_t               resp_out
);

    pmem_pkg::pmem_resp_t offers [pmem_pkg::PMEM_BANKS];

    // One slice per bank, all sharing the request bus
    for (genvar i = 0; i < pmem_pkg::PMEM_BANKS; i++) begin : g_bank

        pmem_pkg::pmem_req_t  held;
        pmem_pkg::pmem_resp_t rd_resp;
        logic                 consume;
        logic                 ser_empty;

        pmem_req_deser u_deser (
            .bus_clk (bus_clk),
            .rst_n   (rst_n),
            .recv    (recv[i]),
            .req_in  (req_in),
            .consume (consume),
            .held    (held),
            .free    (free[i])
        );

        pmem_bank_ctrl u_ctrl (
            .bus_clk   (bus_clk),
            .rst_n     (rst_n),
            .held      (held),
            .ser_empty (ser_empty),
            .consume   (consume),
            .rd_resp   (rd_resp)
        );

        pmem_resp_ser u_ser (
            .bus_clk   (bus_clk),
            .rst_n     (rst_n),
            .rd_resp   (rd_resp),
            .grant     (grant[i]),
            .ack       (ack[i]),
            .req       (req[i]),
            .rel       (rel[i]),
            .ser_empty (ser_empty),
            .offer     (offers[i])
        );

    end

    pmem_resp_bus u_resp_bus (
        .bus_clk  (bus_clk),
        .rst_n    (rst_n),
        .offers   (offers),
        .resp_out (resp_out)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, then scan the log for the fail message
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_pmem_top \
    -f verilog.f -Mdir obj_dir > build.log 2>&1 ||
    { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_pmem_top > sim.log 2>&1 ||
    { cat sim.log; echo "Simulation run aborted"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "Failures reported in sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "No result line in sim.log"; exit 1; }
exit 0

//--- verification/pmem_props.sv
`timescale 1ns/100ps

module pmem_props (
    input logic                 bus_clk,
    input logic                 rst_n,
    input logic                 grant,
    input logic                 ack,
    input logic                 req,
    input logic                 rel,
    input pmem_pkg::pmem_resp_t offer
);

    // Release is a single cycle pulse
    rel_one_cycle: assert property (@(posedge bus_clk) disable iff (!rst_n)
        rel |=> !rel)
        else $error("rel held for more than one cycle");

    rel_after_ack: assert property (@(posedge bus_clk) disable iff (!rst_n)
        rel |-> $past(ack))
        else $error("rel raised without a preceding ack");

    // Request is held until the receiver acknowledges
    req_until_ack: assert property (@(posedge bus_clk) disable iff (!rst_n)
        (req && !ack) |=> req)
        else $error("req dropped before ack");

    ack_needs_req: assert property (@(posedge bus_clk) disable iff (!rst_n)
        ack |-> req)
        else $error("ack seen while no request is pending");

    // Offer only in the first cycle of a grant
    offer_first_grant: assert property (@(posedge bus_clk) disable iff (!rst_n)
        offer.valid |-> (grant && !$past(grant)))
        else $error("response offered outside the first granted cycle");

endmodule

//--- verification/tb_pmem_top.sv
`timescale 1ns/100ps

module tb_pmem_top;

    localparam int RAND_OPS    = 200;
    localparam int HOLD_CYCLES = 12;
    // Rough transaction count summed over the tests
    localparam int TEST_LEN_SUM = 1 + 2 * pmem_pkg::PMEM_BANKS + 1 + 4 + RAND_OPS;
    localparam int CYCLE_LIMIT  = 8 * TEST_LEN_SUM * (pmem_pkg::READ_CYCLES + 6);

    logic                              bus_clk;
    logic                              rst_n;
    pmem_pkg::pmem_req_t               req_in;
    logic [pmem_pkg::PMEM_BANKS-1:0]   recv;
    logic [pmem_pkg::PMEM_BANKS-1:0]   grant;
    logic [pmem_pkg::PMEM_BANKS-1:0]   ack;
    logic [pmem_pkg::PMEM_BANKS-1:0]   free;
    logic [pmem_pkg::PMEM_BANKS-1:0]   req;
    logic [pmem_pkg::PMEM_BANKS-1:0]   rel;
    pmem_pkg::pmem_resp_t              resp_out;

    logic [pmem_pkg::DATA_W-1:0] shadow [pmem_pkg::PMEM_BANKS][pmem_pkg::BANK_WORDS];
    bit                          shadow_wr [pmem_pkg::PMEM_BANKS][pmem_pkg::BANK_WORDS];
    pmem_pkg::pmem_resp_t        exp_q [pmem_pkg::PMEM_BANKS][$];

    integer seed;
    string  test_name;
    int     chk_errors;
    int     cmp_errors;
    int     err_mark;
    int     tests_passed;
    int     tests_failed;
    int     reads_issued;
    int     resp_count;
    int     cycles;
    int     gnt_bank;
    bit     ack_due;
    int     cmp_bank;
    int     edges;
    int     bank;
    int     rd_mark;
    int     resp_mark;
    logic   [pmem_pkg::PMEM_BANKS-1:0] hold_mask;
    logic   [pmem_pkg::ADDR_W-1:0]     addr_a;
    logic   [pmem_pkg::ADDR_W-1:0]     addr_b;
    pmem_pkg::pmem_resp_t              cmp_exp;

    pmem_top DUT (
        .bus_clk  (bus_clk),
        .rst_n    (rst_n),
        .req_in   (req_in),
        .recv     (recv),
        .grant    (grant),
        .ack      (ack),
        .free     (free),
        .req      (req),
        .rel      (rel),
        .resp_out (resp_out)
    );

    bind pmem_resp_ser pmem_props u_props (
        .bus_clk (bus_clk),
        .rst_n   (rst_n),
        .grant   (grant),
        .ack     (ack),
        .req     (req),
        .rel     (rel),
        .offer   (offer)
    );

    initial bus_clk = 1'b0;
    always #20 bus_clk = ~bus_clk;

    // Expected response from the shadow memory
    function automatic pmem_pkg::pmem_resp_t expected_resp(input int b,
            input logic [pmem_pkg::ADDR_W-1:0] addr, input logic [pmem_pkg::ID_W-1:0] src);
        pmem_pkg::pmem_resp_t r;
        int w;
        w = int'(addr[pmem_pkg::ADDR_W-1 -: pmem_pkg::BANK_AW]);
        r = '0;
        r.valid = 1'b1;
        r.dest  = src;
        r.src   = pmem_pkg::BANK_ID_BASE + pmem_pkg::ID_W'(b);
        r.addr  = addr;
        if (shadow_wr[b][w]) begin
            r.data = shadow[b][w];
        end
        return r;
    endfunction

    function automatic logic [pmem_pkg::ADDR_W-1:0] make_addr(input int word,
            input logic [31:0] low);
        logic [pmem_pkg::ADDR_W-1:0] a;
        a = low[pmem_pkg::ADDR_W-1:0];
        a[pmem_pkg::ADDR_W-1 -: pmem_pkg::BANK_AW] = word[pmem_pkg::BANK_AW-1:0];
        return a;
    endfunction

    function automatic logic [pmem_pkg::DATA_W-1:0] rand_data();
        logic [pmem_pkg::DATA_W-1:0] d;
        for (int k = 0; k < pmem_pkg::DATA_W / 32; k++) begin
            d[k*32 +: 32] = $random(seed);
        end
        return d;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int b = 0; b < pmem_pkg::PMEM_BANKS; b++) begin
            n += exp_q[b].size();
        end
        return n;
    endfunction

    // Starts on a falling edge and returns on the one after capture
    task automatic issue(input int b, input logic rw, input logic [pmem_pkg::ADDR_W-1:0] addr,
            input logic [pmem_pkg::DATA_W-1:0] data, input logic [pmem_pkg::ID_W-1:0] src);
        int w;
        w = int'(addr[pmem_pkg::ADDR_W-1 -: pmem_pkg::BANK_AW]);
        while (!free[b]) begin
            @(negedge bus_clk);
        end
        req_in = '{valid: 1'b1, rw: rw, addr: addr, data: data, src: src};
        recv[b] = 1'b1;
        if (rw) begin
            exp_q[b].push_back(expected_resp(b, addr, src));
            reads_issued++;
        end else begin
            shadow[b][w]    = data;
            shadow_wr[b][w] = 1'b1;
        end
        @(negedge bus_clk);
        recv   = '0;
        req_in = '0;
    endtask

    task automatic drain();
        while (pending() != 0 || req != '0 || rel != '0 || grant != '0) begin
            @(negedge bus_clk);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what,
                     expected, actual);
            chk_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = chk_errors + cmp_errors;
    endtask

    task automatic end_test();
        int errs;
        errs = chk_errors + cmp_errors - err_mark;
        if (errs == 0) begin
            $display("PASS  %s", test_name);
            tests_passed++;
        end else begin
            $display("FAIL  %s (%0d errors)", test_name, errs);
            tests_failed++;
        end
    endtask

    // Arbiter model granting one bank at a time
    initial begin
        grant    = '0;
        ack      = '0;
        gnt_bank = -1;
        ack_due  = 1'b0;
        forever begin
            @(negedge bus_clk);
            ack = '0;
            if (!rst_n) begin
                grant    = '0;
                gnt_bank = -1;
                ack_due  = 1'b0;
            end else if (gnt_bank < 0) begin
                for (int i = 0; i < pmem_pkg::PMEM_BANKS; i++) begin
                    if (gnt_bank < 0 && req[i] && !hold_mask[i]) begin
                        gnt_bank = i;
                        grant[i] = 1'b1;
                    end
                end
            end else begin
                if (ack_due) begin
                    ack[gnt_bank] = 1'b1;
                    ack_due       = 1'b0;
                end else if (resp_out.valid) begin
                    ack_due = 1'b1;
                end
                if (rel[gnt_bank]) begin
                    grant    = '0;
                    gnt_bank = -1;
                end
            end
        end
    end

    // Response checker
    initial begin
        forever begin
            @(negedge bus_clk);
            if (rst_n && resp_out.valid) begin
                resp_count++;
                cmp_bank = int'(resp_out.src) - int'(pmem_pkg::BANK_ID_BASE);
                if (cmp_bank < 0 || cmp_bank >= pmem_pkg::PMEM_BANKS) begin
                    $display("%s: response carries unknown source id %0h", test_name,
                             resp_out.src);
                    cmp_errors++;
                end else if (exp_q[cmp_bank].size() == 0) begin
                    $display("%s: unexpected response from bank %0d", test_name, cmp_bank);
                    cmp_errors++;
                end else begin
                    cmp_exp = exp_q[cmp_bank].pop_front();
                    if (resp_out !== cmp_exp) begin
                        $display("[ERROR] %s: expected %h, actual %h", test_name, cmp_exp,
                                 resp_out);
                        cmp_errors++;
                    end
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge bus_clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        seed      = 32'h5c20_38cd;
        rst_n     = 1'b0;
        req_in    = '0;
        recv      = '0;
        hold_mask = '0;
        repeat (10) @(posedge bus_clk);
        @(negedge bus_clk);
        rst_n = 1'b1;

        begin_test("reset_state");
        @(negedge bus_clk);
        check_value("free", 32'hf, 32'(free));
        check_value("req", 0, 32'(req));
        check_value("rel", 0, 32'(rel));
        check_value("resp valid", 0, 32'(resp_out.valid));
        end_test();

        begin_test("write_read_per_bank");
        for (int b = 0; b < pmem_pkg::PMEM_BANKS; b++) begin
            addr_a = make_addr(3 * b + 1, $random(seed));
            issue(b, 1'b0, addr_a, rand_data(), 4'h0);
            issue(b, 1'b1, addr_a, '0, pmem_pkg::ID_W'($random(seed)));
        end
        drain();
        end_test();

        begin_test("read_timing");
        issue(0, 1'b1, make_addr(1, 32'h15), '0, 4'h3);
        edges = 0;
        while (!req[0] && edges < 4 * pmem_pkg::READ_CYCLES) begin
            @(negedge bus_clk);
            edges++;
        end
        check_value("req rise edges", pmem_pkg::READ_CYCLES + 1, edges);
        check_value("free at req rise", 1, 32'(free[0]));
        check_value("valid before grant", 0, 32'(resp_out.valid));
        @(negedge bus_clk);
        check_value("valid after grant edge", 1, 32'(resp_out.valid));
        @(negedge bus_clk);
        check_value("valid second cycle", 0, 32'(resp_out.valid));
        check_value("rel before ack", 0, 32'(rel[0]));
        @(negedge bus_clk);
        check_value("rel after ack", 1, 32'(rel[0]));
        check_value("req after ack", 0, 32'(req[0]));
        @(negedge bus_clk);
        check_value("rel width", 0, 32'(rel[0]));
        drain();
        end_test();

        begin_test("back_pressure");
        hold_mask = 4'b0100;
        addr_a = make_addr(5, $random(seed));
        addr_b = make_addr(6, $random(seed));
        issue(2, 1'b0, addr_a, rand_data(), 4'h0);
        issue(2, 1'b0, addr_b, rand_data(), 4'h0);
        issue(2, 1'b1, addr_a, '0, 4'h1);
        issue(2, 1'b1, addr_b, '0, 4'h2);
        resp_mark = resp_count;
        repeat (HOLD_CYCLES) begin
            @(negedge bus_clk);
            check_value("free while held", 0, 32'(free[2]));
            check_value("req while held", 1, 32'(req[2]));
        end
        hold_mask = '0;
        drain();
        check_value("responses", 2, resp_count - resp_mark);
        end_test();

        begin_test("random_traffic");
        rd_mark   = reads_issued;
        resp_mark = resp_count;
        for (int n = 0; n < RAND_OPS; n++) begin
            bank   = int'($unsigned($random(seed)) % pmem_pkg::PMEM_BANKS);
            addr_a = make_addr(int'($unsigned($random(seed)) % 8), $random(seed));
            issue(bank, 1'($random(seed)), addr_a, rand_data(),
                  pmem_pkg::ID_W'($random(seed)));
        end
        drain();
        check_value("response count", reads_issued - rd_mark, resp_count - resp_mark);
        end_test();

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && chk_errors + cmp_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/pmem_pkg.sv
rtl/pmem_req_deser.sv
rtl/pmem_bank_ctrl.sv
rtl/pmem_resp_ser.sv
rtl/pmem_resp_bus.sv
rtl/pmem_top.sv
verification/pmem_props.sv
verification/tb_pmem_top.sv
